// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_qla
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+source
+incdir+test
source/qla_pkg.sv
source/reg_decode.sv
source/motor_channel.sv
source/dac_spi.sv
source/quad_encoder.sv
source/qla_top.sv
test/tb_qla.sv

// File: source/dac_spi.sv
// SPI serializer that sends one DAC frame per axis on each start pulse
`include "qla_cfg.svh"

module dac_spi import qla_pkg::*; (
    input  logic     sysclk,
    input  logic     rst,
    input  logic     dac_start,
    input  cur_cmd_t cur_cmd [`QLA_NUM_CHAN],
    output logic     busy,
    output logic     sclk,       // sysclk / 2, idle low
    output logic     mosi,
    output logic     csel        // Active low
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FRAME = 2'd1;
    localparam logic [1:0] ST_GAP   = 2'd2;

    localparam logic [4:0] LAST_BIT  = 5'(`DAC_FRAME_BITS - 1);
    localparam logic [1:0] LAST_GAP  = 2'(`DAC_GAP_CYCLES - 1);
    localparam chan_idx_t  LAST_CHAN = chan_idx_t'(`QLA_NUM_CHAN - 1);

    logic [1:0] state;
    logic [4:0] bit_cnt;
    logic [1:0] gap_cnt;
    chan_idx_t  chan;
    reg_word_t  shreg;       // MSB out first
    cur_cmd_t   cmd_q [`QLA_NUM_CHAN];

    // Command, axis index, code, 8 zeros
    function automatic reg_word_t build_frame(input chan_idx_t idx, input cur_cmd_t code);
        return {`DAC_CMD_WRUP, 2'b00, idx, code, 8'd0};
    endfunction

    assign mosi = shreg[31];

    // Snapshot of all commands at start
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && dac_start)
            cmd_q <= cur_cmd;
    end

    // ------------------------------
    // Frame sequencer
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state   <= ST_IDLE;
            busy    <= 1'b0;
            sclk    <= 1'b0;
            csel    <= 1'b1;
            bit_cnt <= '0;
            gap_cnt <= '0;
            chan    <= '0;
            shreg   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (dac_start) begin
                    busy    <= 1'b1;
                    csel    <= 1'b0;
                    chan    <= '0;
                    bit_cnt <= '0;
                    shreg   <= build_frame('0, cur_cmd[0]);   // Axis 0 straight from input
                    state   <= ST_FRAME;
                end
                ST_FRAME: begin
                    sclk <= ~sclk;
                    if (sclk) begin                     // Falling edge, next bit out
                        shreg   <= {shreg[30:0], 1'b0};
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == LAST_BIT) begin
                            csel    <= 1'b1;
                            gap_cnt <= '0;
                            if (chan == LAST_CHAN) begin
                                busy  <= 1'b0;          // End of burst
                                state <= ST_IDLE;
                            end else begin
                                state <= ST_GAP;
                            end
                        end
                    end
                end
                ST_GAP: begin
                    gap_cnt <= gap_cnt + 2'd1;
                    if (gap_cnt == LAST_GAP) begin
                        chan    <= chan + 2'd1;
                        shreg   <= build_frame(chan + 2'd1, cmd_q[chan + 2'd1]);
                        bit_cnt <= '0;
                        csel    <= 1'b0;
                        state   <= ST_FRAME;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Chip select never asserted outside a burst
    a_csel_idle : assert property (@(posedge sysclk) disable iff (rst) !busy |-> csel);

endmodule

// File: source/motor_channel.sv
// Per-axis commanded current, amplifier enable and fault latch, one instance per axis
`include "qla_cfg.svh"

module motor_channel import qla_pkg::*; (
    input  logic      sysclk,
    input  logic      rst,
    input  logic      dac_wen,       // DAC_CTRL write strobe
    input  chan_wr_u  wdata,
    input  logic      amp_fault_n,   // Active low, async
    output cur_cmd_t  cur_cmd,
    output logic      amp_en,
    output reg_word_t dac_word,
    output reg_word_t status
);

    logic [1:0] fault_sync;   // Two-flop synchronizer
    logic       fault_flag;   // Sticky until re-enabled

    always_ff @(posedge sysclk) begin
        if (rst) begin
            fault_sync <= 2'b11;     // No fault
            cur_cmd    <= '0;
            amp_en     <= 1'b0;
            fault_flag <= 1'b0;
        end else begin
            fault_sync <= {fault_sync[0], amp_fault_n};
            if (dac_wen)
                cur_cmd <= wdata.dac_ctrl.cur_cmd;   // Every write

            // Fault beats a simultaneous enable
            if (amp_en && !fault_sync[1]) begin
                amp_en     <= 1'b0;
                fault_flag <= 1'b1;
            end else if (dac_wen && wdata.dac_ctrl.amp_en_valid) begin
                amp_en     <= wdata.dac_ctrl.amp_en;
                fault_flag <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Readback words
    // ------------------------------
    always_comb begin
        dac_word              = '0;
        dac_word[`DAC_EN_BIT] = amp_en;
        dac_word[15:0]        = cur_cmd;
    end

    assign status = {29'd0, fault_flag, amp_en, fault_sync[1]};

    // Amp stays off while a fault is latched
    a_fault_shutdown : assert property (@(posedge sysclk) disable iff (rst)
        fault_flag |-> !amp_en);

endmodule

// File: source/qla_cfg.svh
// Address map, widths and DAC frame constants, included by the package and by every RTL module
`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// Board geometry
`define QLA_NUM_CHAN      4

// ------------------------------
// Address map
// ------------------------------
`define ADDR_MAIN         4'h0      // Only decoded space, addr[15:12]
`define OFF_STATUS        4'h0      // Channel 0 global status
`define OFF_DAC_CTRL      4'h1      // Commanded current and amp enable
`define OFF_ENC_LOAD      4'h4      // Encoder preload
`define OFF_ENC_DATA      4'h5      // Encoder position
`define OFF_MOTOR_STATUS  4'hC      // Per-axis fault and enable state

// Encoder counter
`define ENC_WIDTH         24
`define ENC_MIDRANGE      24'h800000

// ------------------------------
// DAC frame
// ------------------------------
`define DAC_CMD_WRUP      4'h3      // Write and update
`define DAC_FRAME_BITS    32
`define DAC_GAP_CYCLES    2         // CS high between frames
`define DAC_EN_VALID_BIT  29
`define DAC_EN_BIT        28

`endif

// File: source/qla_pkg.sv
// Shared register types and the channel write-word union, imported by every RTL module
`include "qla_cfg.svh"

package qla_pkg;

    typedef logic [15:0]            reg_addr_t;   // Space, channel, offset nibbles
    typedef logic [31:0]            reg_word_t;
    typedef logic [15:0]            cur_cmd_t;    // DAC code
    typedef logic [`ENC_WIDTH-1:0]  enc_count_t;
    typedef logic [1:0]             chan_idx_t;   // Axis 0..3

    // ------------------------------
    // Channel write word
    // ------------------------------
    // DAC_CTRL view
    typedef struct packed {
        logic [30-`DAC_EN_VALID_BIT:0] rsvd_hi;
        logic                          amp_en_valid;  // Bit 29
        logic                          amp_en;        // Bit 28
        logic [`DAC_EN_BIT-17:0]       rsvd_lo;
        cur_cmd_t                      cur_cmd;
    } dac_ctrl_t;

    // ENC_LOAD view
    typedef struct packed {
        logic [31-`ENC_WIDTH:0] rsvd;
        enc_count_t             preload;
    } enc_load_t;

    // Same 32-bit bus word, decoded per target offset
    typedef union packed {
        dac_ctrl_t dac_ctrl;
        enc_load_t enc_load;
    } chan_wr_u;

endpackage

// File: source/qla_top.sv
// Top level of the motor controller register core; instantiate as the board's register block
`include "qla_cfg.svh"

module qla_top import qla_pkg::*; (
    input  logic                      sysclk,
    input  logic                      rst,
    input  logic [3:0]                board_id,     // Rotary switch
    // Host register bus
    input  reg_addr_t                 reg_raddr,
    input  reg_addr_t                 reg_waddr,
    input  reg_word_t                 reg_wdata,
    input  logic                      reg_wen,
    input  logic                      blk_wen,
    output reg_word_t                 reg_rdata,
    // Axis pins
    input  logic [`QLA_NUM_CHAN-1:0]  enc_a,
    input  logic [`QLA_NUM_CHAN-1:0]  enc_b,
    input  logic [`QLA_NUM_CHAN-1:0]  amp_fault_n,  // Active low
    output logic [`QLA_NUM_CHAN-1:0]  amp_enable,
    // Serial DAC
    output logic                      dac_sclk,
    output logic                      dac_mosi,
    output logic                      dac_csel
);

    logic [`QLA_NUM_CHAN-1:0] dac_wen;    // Per-axis write strobes
    logic [`QLA_NUM_CHAN-1:0] load_wen;
    logic                     dac_start;
    logic                     dac_busy;

    cur_cmd_t   cur_cmd   [`QLA_NUM_CHAN];
    reg_word_t  dac_word  [`QLA_NUM_CHAN];
    reg_word_t  status    [`QLA_NUM_CHAN];
    enc_count_t enc_count [`QLA_NUM_CHAN];
    enc_count_t preload   [`QLA_NUM_CHAN];

    reg_decode decode (
        .sysclk        (sysclk),
        .rst           (rst),
        .reg_raddr     (reg_raddr),
        .reg_waddr     (reg_waddr),
        .reg_wen       (reg_wen),
        .blk_wen       (blk_wen),
        .board_id      (board_id),
        .dac_busy      (dac_busy),
        .chan_dac_word (dac_word),
        .chan_status   (status),
        .enc_count     (enc_count),
        .enc_preload   (preload),
        .reg_rdata     (reg_rdata),
        .dac_wen       (dac_wen),
        .load_wen      (load_wen),
        .dac_start     (dac_start)
    );

    // ------------------------------
    // Per-axis datapath
    // ------------------------------
    genvar k;
    generate
        for (k = 0; k < `QLA_NUM_CHAN; k++) begin : axis
            motor_channel motor (
                .sysclk      (sysclk),
                .rst         (rst),
                .dac_wen     (dac_wen[k]),
                .wdata       (reg_wdata),
                .amp_fault_n (amp_fault_n[k]),
                .cur_cmd     (cur_cmd[k]),
                .amp_en      (amp_enable[k]),
                .dac_word    (dac_word[k]),
                .status      (status[k])
            );

            quad_encoder enc (
                .sysclk   (sysclk),
                .rst      (rst),
                .enc_a    (enc_a[k]),
                .enc_b    (enc_b[k]),
                .load_wen (load_wen[k]),
                .wdata    (reg_wdata),
                .count    (enc_count[k]),
                .preload  (preload[k])
            );
        end
    endgenerate

    // One burst carries all four axes
    dac_spi dac (
        .sysclk    (sysclk),
        .rst       (rst),
        .dac_start (dac_start),
        .cur_cmd   (cur_cmd),
        .busy      (dac_busy),
        .sclk      (dac_sclk),
        .mosi      (dac_mosi),
        .csel      (dac_csel)
    );

endmodule

// File: source/quad_encoder.sv
// Per-axis 4x quadrature decoder and position counter with host preload
`include "qla_cfg.svh"

module quad_encoder import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic       enc_a,
    input  logic       enc_b,
    input  logic       load_wen,   // ENC_LOAD write strobe
    input  chan_wr_u   wdata,
    output enc_count_t count,
    output enc_count_t preload
);

    logic [1:0] a_sync;      // Two-flop synchronizers
    logic [1:0] b_sync;
    logic       a_prev;      // Last sampled state
    logic       b_prev;
    logic       step;        // Exactly one input changed
    logic       up;          // A leads B

    always_ff @(posedge sysclk) begin
        a_sync <= {a_sync[0], enc_a};
        b_sync <= {b_sync[0], enc_b};
        a_prev <= a_sync[1];
        b_prev <= b_sync[1];
    end

    // Both changing at once is illegal, no count
    assign step = (a_sync[1] ^ a_prev) ^ (b_sync[1] ^ b_prev);
    assign up   = a_sync[1] ^ b_prev;

    // ------------------------------
    // Counter
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            count   <= `ENC_MIDRANGE;
            preload <= '0;
        end else if (load_wen) begin
            preload <= wdata.enc_load.preload;
            count   <= wdata.enc_load.preload;   // Load wins over a step
        end else if (step) begin
            if (up)
                count <= count + 1'b1;
            else
                count <= count - 1'b1;           // Wraps modulo 2^ENC_WIDTH
        end
    end

endmodule

// File: source/reg_decode.sv
// Register address decode, write strobes, read mux and DAC update request for the core
`include "qla_cfg.svh"

module reg_decode import qla_pkg::*; (
    input  logic                      sysclk,
    input  logic                      rst,
    input  reg_addr_t                 reg_raddr,
    input  reg_addr_t                 reg_waddr,
    input  logic                      reg_wen,
    input  logic                      blk_wen,
    input  logic [3:0]                board_id,
    input  logic                      dac_busy,
    input  reg_word_t                 chan_dac_word [`QLA_NUM_CHAN],
    input  reg_word_t                 chan_status   [`QLA_NUM_CHAN],
    input  enc_count_t                enc_count     [`QLA_NUM_CHAN],
    input  enc_count_t                enc_preload   [`QLA_NUM_CHAN],
    output reg_word_t                 reg_rdata,
    output logic [`QLA_NUM_CHAN-1:0]  dac_wen,
    output logic [`QLA_NUM_CHAN-1:0]  load_wen,
    output logic                      dac_start
);

    localparam logic [3:0] LAST_CHAN = 4'(`QLA_NUM_CHAN);

    logic [3:0] wchan_m1;     // Channel 1..4 -> index 0..3
    logic [3:0] rchan_m1;
    logic       wchan_ok;     // Main space, axis channel
    logic       rchan_ok;
    logic       dac_req;      // Pending burst
    reg_word_t  status_word;

    // ------------------------------
    // Write side
    // ------------------------------
    assign wchan_m1 = reg_waddr[7:4] - 4'd1;
    assign wchan_ok = (reg_waddr[15:12] == `ADDR_MAIN) && (reg_waddr[7:4] != 4'd0) &&
                      (reg_waddr[7:4] <= LAST_CHAN);

    always_comb begin
        dac_wen  = '0;
        load_wen = '0;
        if (reg_wen && wchan_ok) begin
            if (reg_waddr[3:0] == `OFF_DAC_CTRL)
                dac_wen[wchan_m1[1:0]] = 1'b1;
            if (reg_waddr[3:0] == `OFF_ENC_LOAD)
                load_wen[wchan_m1[1:0]] = 1'b1;
        end
    end

    // Block write to any DAC_CTRL asks for one burst; repeats merge
    always_ff @(posedge sysclk) begin
        if (rst) begin
            dac_req   <= 1'b0;
            dac_start <= 1'b0;
        end else begin
            dac_start <= 1'b0;
            if (blk_wen && wchan_ok && (reg_waddr[3:0] == `OFF_DAC_CTRL)) begin
                dac_req <= 1'b1;
            end else if (dac_req && !dac_busy && !dac_start) begin
                dac_req   <= 1'b0;
                dac_start <= 1'b1;   // Busy follows one cycle later
            end
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------
    assign rchan_m1 = reg_raddr[7:4] - 4'd1;
    assign rchan_ok = (reg_raddr[7:4] != 4'd0) && (reg_raddr[7:4] <= LAST_CHAN);

    always_comb begin
        status_word        = '0;
        status_word[31:28] = board_id;
        status_word[0]     = dac_busy;
        for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
            status_word[8 + i] = chan_status[i][1];   // Amp enable
            status_word[4 + i] = chan_status[i][2];   // Fault latch
        end
    end

    // Combinational, same cycle as reg_raddr
    always_comb begin
        reg_rdata = '0;
        if (reg_raddr[15:12] == `ADDR_MAIN) begin
            if (reg_raddr[7:4] == 4'd0) begin
                if (reg_raddr[3:0] == `OFF_STATUS)
                    reg_rdata = status_word;
            end else if (rchan_ok) begin
                case (reg_raddr[3:0])
                    `OFF_DAC_CTRL:     reg_rdata = chan_dac_word[rchan_m1[1:0]];
                    `OFF_ENC_LOAD:     reg_rdata = {{(32-`ENC_WIDTH){1'b0}},
                                                    enc_preload[rchan_m1[1:0]]};
                    `OFF_ENC_DATA:     reg_rdata = {{(32-`ENC_WIDTH){1'b0}},
                                                    enc_count[rchan_m1[1:0]]};
                    `OFF_MOTOR_STATUS: reg_rdata = chan_status[rchan_m1[1:0]];
                    default:           reg_rdata = '0;
                endcase
            end
        end
    end

    // Request logic must respect the serializer's busy level
    a_start_not_busy : assert property (@(posedge sysclk) disable iff (rst)
        !(dac_start && dac_busy));

endmodule

// File: test/tb_qla_tests.svh
// Bus helpers and directed test tasks, included inside the testbench top module

// Space 0, channel nibble, offset nibble
function automatic reg_addr_t chan_addr(input int chan, input logic [3:0] off);
    return {`ADDR_MAIN, 4'h0, 4'(chan), off};
endfunction

// Global status word as the address map defines it
function automatic reg_word_t status_exp(input logic [3:0] en, input logic [3:0] flt,
                                         input logic busy);
    return {BOARD_ID, 16'd0, en, flt, 3'd0, busy};
endfunction

task automatic tick();
    @(posedge sysclk);
    #1;
endtask

task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
    reg_waddr = addr;
    reg_wdata = data;
    reg_wen   = 1'b1;
    tick();
    reg_wen   = 1'b0;
endtask

task automatic blk_pulse(input reg_addr_t addr);
    reg_waddr = addr;
    blk_wen   = 1'b1;
    tick();
    blk_wen   = 1'b0;
endtask

// Combinational read, sampled mid-cycle
task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
    reg_raddr = addr;
    @(negedge sysclk);
    data = reg_rdata;
    tick();
endtask

task automatic wait_busy(input logic level, input int limit);
    reg_word_t rd;
    int        n;
    n = 0;
    read_reg(chan_addr(0, `OFF_STATUS), rd);
    while (rd[0] !== level && n < limit) begin
        read_reg(chan_addr(0, `OFF_STATUS), rd);
        n++;
    end
    if (rd[0] !== level) begin
        errors++;
        $display("ERROR at %0t: dac_busy did not go %0b within %0d cycles", $time, level, limit);
    end
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic test_reset();
    reg_word_t rd;
    read_reg(chan_addr(0, `OFF_STATUS), rd);
    check_word("status", rd, status_exp(4'd0, 4'd0, 1'b0));
    for (int c = 1; c <= 4; c++) begin
        read_reg(chan_addr(c, `OFF_DAC_CTRL), rd);
        check_word($sformatf("dac_ctrl ch%0d", c), rd, 32'd0);
        read_reg(chan_addr(c, `OFF_ENC_DATA), rd);
        check_word($sformatf("enc_data ch%0d", c), rd, reg_word_t'(`ENC_MIDRANGE));
        check_bit($sformatf("amp_enable[%0d]", c - 1), amp_enable[c - 1], 1'b0);
    end
    check_bit("dac_csel", dac_csel, 1'b1);
    check_bit("dac_sclk", dac_sclk, 1'b0);
endtask

task automatic test_registers();
    cur_cmd_t  vals [4];
    reg_word_t rd;
    reg_addr_t unmapped [6] = '{16'h0012, 16'h0003, 16'h0061, 16'h1011, 16'h001F, 16'h0051};
    for (int i = 0; i < 4; i++) begin
        vals[i] = cur_cmd_t'(rand_bits(16));
        write_reg(chan_addr(i + 1, `OFF_DAC_CTRL), reg_word_t'(vals[i]));
    end
    // Ignored: channel 0, channel 6, space 1; enable bits set to catch a leak
    write_reg(chan_addr(0, `OFF_DAC_CTRL), 32'h3000_5A5A);
    write_reg(chan_addr(6, `OFF_DAC_CTRL), 32'h3000_A5A5);
    write_reg(16'h1011, 32'h3000_0F0F);
    write_reg(16'h1014, 32'h0012_3456);
    for (int i = 0; i < 4; i++) begin
        read_reg(chan_addr(i + 1, `OFF_DAC_CTRL), rd);
        check_word($sformatf("dac_ctrl ch%0d", i + 1), rd, reg_word_t'(vals[i]));
        check_bit($sformatf("amp_enable[%0d]", i), amp_enable[i], 1'b0);
    end
    read_reg(chan_addr(1, `OFF_ENC_LOAD), rd);
    check_word("enc_load ch1", rd, 32'd0);
    read_reg(chan_addr(0, `OFF_STATUS), rd);
    check_word("status", rd, status_exp(4'd0, 4'd0, 1'b0));
    foreach (unmapped[k]) begin
        read_reg(unmapped[k], rd);
        check_word($sformatf("rdata @%h", unmapped[k]), rd, 32'd0);
    end
endtask

task automatic test_dac_burst();
    cur_cmd_t  old_val [4];
    cur_cmd_t  new_val [4];
    reg_word_t exp;
    int        base;
    base = frames.size();
    for (int i = 0; i < 4; i++) begin
        old_val[i] = cur_cmd_t'(rand_bits(16));
        write_reg(chan_addr(i + 1, `OFF_DAC_CTRL), reg_word_t'(old_val[i]));
    end
    blk_pulse(chan_addr(2, `OFF_DAC_CTRL));
    wait_busy(1'b1, 10);
    // New values and two requests mid-burst, merged into one
    for (int i = 0; i < 4; i++) begin
        new_val[i] = cur_cmd_t'(rand_bits(16));
        write_reg(chan_addr(i + 1, `OFF_DAC_CTRL), reg_word_t'(new_val[i]));
    end
    blk_pulse(chan_addr(1, `OFF_DAC_CTRL));
    blk_pulse(chan_addr(4, `OFF_DAC_CTRL));
    while (frames.size() < base + 8 && $time < 64'(WATCHDOG_CYC) * 8) tick();
    repeat (BURST_CYC + 20) tick();   // Room for a stray third burst
    if (frames.size() != base + 8) begin
        errors++;
        $display("ERROR at %0t: expected 8 DAC frames, saw %0d", $time, frames.size() - base);
    end
    for (int f = 0; f < 8 && base + f < frames.size(); f++) begin
        exp = {`DAC_CMD_WRUP, 4'(f % 4), (f < 4) ? old_val[f % 4] : new_val[f % 4], 8'd0};
        check_word($sformatf("dac frame %0d", f), frames[base + f], exp);
    end
    wait_busy(1'b0, BURST_CYC);
    check_bit("dac_csel", dac_csel, 1'b1);
    check_bit("dac_sclk", dac_sclk, 1'b0);
endtask

// Gray phases 00, 10, 11, 01 as (A, B); forward means A leads
task automatic enc_move(input int idx, input int steps, input bit fwd);
    for (int s = 0; s < steps; s++) begin
        enc_phase[idx] = fwd ? enc_phase[idx] + 2'd1 : enc_phase[idx] - 2'd1;
        enc_a[idx]     = (enc_phase[idx] == 2'd1) || (enc_phase[idx] == 2'd2);
        enc_b[idx]     = enc_phase[idx][1];
        repeat (8) tick();
    end
endtask

task automatic enc_run(input int chan, input enc_count_t pre, input int n, input int m);
    reg_word_t rd;
    write_reg(chan_addr(chan, `OFF_ENC_LOAD), reg_word_t'(pre));
    read_reg(chan_addr(chan, `OFF_ENC_LOAD), rd);
    check_word($sformatf("enc_load ch%0d", chan), rd, reg_word_t'(pre));
    read_reg(chan_addr(chan, `OFF_ENC_DATA), rd);
    check_count($sformatf("enc count ch%0d", chan), enc_count_t'(rd), pre);
    enc_move(chan - 1, n, 1'b1);
    enc_move(chan - 1, m, 1'b0);
    read_reg(chan_addr(chan, `OFF_ENC_DATA), rd);
    check_word($sformatf("enc_data high ch%0d", chan), rd & 32'hFF00_0000, 32'd0);
    check_count($sformatf("enc count ch%0d", chan), enc_count_t'(rd),
                pre + enc_count_t'(n) - enc_count_t'(m));
endtask

task automatic test_encoder();
    enc_count_t pre;
    int         n;
    int         m;
    pre = enc_count_t'(rand_bits(`ENC_WIDTH));
    n   = int'(rand_bits(5)) + 1;
    m   = int'(rand_bits(4)) + 1;
    enc_run(2, pre, n, m);
    enc_run(3, 24'hFFFFFD, 5, 0);   // Wraps up through zero
    enc_run(1, 24'h000002, 0, 4);   // Wraps down
endtask

task automatic test_amp_fault();
    reg_word_t rd;
    reg_word_t en_word;
    en_word                    = 32'h0000_1234;
    en_word[`DAC_EN_VALID_BIT] = 1'b1;
    en_word[`DAC_EN_BIT]       = 1'b1;
    write_reg(chan_addr(3, `OFF_DAC_CTRL), en_word);
    check_bit("amp_enable[2]", amp_enable[2], 1'b1);
    read_reg(chan_addr(3, `OFF_MOTOR_STATUS), rd);
    check_word("motor_status ch3", rd, 32'h3);   // Enabled, fault input high
    read_reg(chan_addr(3, `OFF_DAC_CTRL), rd);
    check_word("dac_ctrl ch3", rd, 32'h1000_1234);
    read_reg(chan_addr(0, `OFF_STATUS), rd);
    check_word("status", rd, status_exp(4'b0100, 4'b0000, 1'b0));
    // Fault pulse, then input released
    amp_fault_n[2] = 1'b0;
    repeat (4) tick();
    amp_fault_n[2] = 1'b1;
    repeat (4) tick();
    check_bit("amp_enable[2]", amp_enable[2], 1'b0);
    read_reg(chan_addr(3, `OFF_MOTOR_STATUS), rd);
    check_word("motor_status ch3", rd, 32'h5);
    read_reg(chan_addr(0, `OFF_STATUS), rd);
    check_word("status", rd, status_exp(4'b0000, 4'b0100, 1'b0));
    // Re-enable clears the latch
    write_reg(chan_addr(3, `OFF_DAC_CTRL), en_word);
    check_bit("amp_enable[2]", amp_enable[2], 1'b1);
    read_reg(chan_addr(3, `OFF_MOTOR_STATUS), rd);
    check_word("motor_status ch3", rd, 32'h3);
    read_reg(chan_addr(0, `OFF_STATUS), rd);
    check_word("status", rd, status_exp(4'b0100, 4'b0000, 1'b0));
endtask

// File: test/tb_qla.sv
// Testbench top for the motor controller register core; directed tests come from the header
`include "qla_cfg.svh"

module tb_qla import qla_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] BOARD_ID  = 4'hA;
    localparam int         BURST_CYC = 4 * 2 * `DAC_FRAME_BITS + 3 * `DAC_GAP_CYCLES + 4;
    localparam int         ENC_STEPS = 32 + 16 + 5 + 4;   // Worst case over all encoder runs
    localparam int         WATCHDOG_CYC = 4 + 200           // Reset and register tests
                                        + 3 * BURST_CYC + 100  // Two bursts, idle check
                                        + ENC_STEPS * 8 + 60
                                        + 80                 // Amp fault test
                                        + 500;               // Margin

    logic                     sysclk = 1'b0;
    logic                     rst;
    logic [3:0]               board_id;
    reg_addr_t                reg_raddr;
    reg_addr_t                reg_waddr;
    reg_word_t                reg_wdata;
    reg_word_t                reg_rdata;
    logic                     reg_wen;
    logic                     blk_wen;
    logic [`QLA_NUM_CHAN-1:0] enc_a;
    logic [`QLA_NUM_CHAN-1:0] enc_b;
    logic [`QLA_NUM_CHAN-1:0] amp_fault_n;
    logic [`QLA_NUM_CHAN-1:0] amp_enable;
    logic                     dac_sclk;
    logic                     dac_mosi;
    logic                     dac_csel;

    int          errors = 0;
    int          checks = 0;
    logic [15:0] lfsr = 16'd40437;   // Seed
    reg_word_t   frames [$];         // Decoded SPI frames, in arrival order
    reg_word_t   frame_sr;
    int          frame_bits = 0;
    logic [1:0]  enc_phase [`QLA_NUM_CHAN] = '{default: 2'd0};

    qla_top uut (
        .sysclk      (sysclk),
        .rst         (rst),
        .board_id    (board_id),
        .reg_raddr   (reg_raddr),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .blk_wen     (blk_wen),
        .reg_rdata   (reg_rdata),
        .enc_a       (enc_a),
        .enc_b       (enc_b),
        .amp_fault_n (amp_fault_n),
        .amp_enable  (amp_enable),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel)
    );

    always #4 sysclk = ~sysclk;   // 8 ns period

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // ------------------------------
    // SPI monitor
    // ------------------------------
    // sclk high for one full sysclk cycle, mosi stable across it
    always @(negedge sysclk) begin
        if (dac_csel === 1'b1) begin
            if (frame_bits != 0) begin
                errors++;
                $display("ERROR at %0t: DAC frame ended after %0d bits", $time, frame_bits);
            end
            frame_bits = 0;
        end else if (dac_csel === 1'b0 && dac_sclk === 1'b1) begin
            frame_sr = {frame_sr[30:0], dac_mosi};   // MSB first
            frame_bits++;
            if (frame_bits == `DAC_FRAME_BITS) begin
                frames.push_back(frame_sr);
                frame_bits = 0;
            end
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input enc_count_t got, input enc_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    `include "tb_qla_tests.svh"

    initial begin
        rst         = 1'b1;
        board_id    = BOARD_ID;
        reg_raddr   = '0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_wen     = 1'b0;
        blk_wen     = 1'b0;
        enc_a       = '0;
        enc_b       = '0;
        amp_fault_n = '1;           // No faults
        repeat (4) @(posedge sysclk);
        #1 rst = 1'b0;              // Tasks start 1 ns after an edge
        test_reset();
        test_registers();
        test_dac_burst();
        test_encoder();
        test_amp_fault();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYC * 8);
        $display("ERROR: watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule
